/* rtl/video_pkg.sv */
package video_pkg;

    // line states of the sync generator.
    // The passive group follows the camera href edges during the visible lines.
    // The active group runs the blanking lines on its own from the measured gap.
    typedef enum logic [2:0] {
        passive_h_active = 3'b000,
        passive_h_fp     = 3'b001,
        passive_h_sync   = 3'b010,
        passive_wait_ref = 3'b011,
        active_h_active  = 3'b100,
        active_h_fp      = 3'b101,
        active_h_sync    = 3'b110,
        active_wait_ref  = 3'b111
    } sync_state_t;

    // read side of the line buffer.
    // It runs for as long as de stays high and then rests until the next line.
    typedef enum logic {
        rd_idle = 1'b0,
        rd_run  = 1'b1
    } rd_state_t;

endpackage : video_pkg

/* rtl/sync_gen.sv */
`timescale 1ns/1ps

module sync_gen #(
    parameter int H_ACT  = 1280,
    parameter int H_FP   = 110,
    parameter int H_SYNC = 40,
    parameter int V_ACT  = 720,
    parameter int V_FP   = 5,
    parameter int V_SYNC = 5
) (
    input  logic clk,
    input  logic rstn,
    input  logic cam_href,
    input  logic cam_vsync,
    output logic hsync,
    output logic vsync,
    output logic de
);

    localparam int H_TOTAL = H_ACT + H_FP + H_SYNC;
    localparam int V_TOTAL = V_ACT + V_FP + V_SYNC;
    // the idle gap may be as long as a whole line, so the horizontal counters
    // carry one spare bit.
    localparam int H_W = $clog2(2 * H_TOTAL);
    localparam int V_W = $clog2(V_TOTAL + 1);

    video_pkg::sync_state_t state;

    logic [H_W-1:0] h_cnt;
    logic [H_W-1:0] h_total;
    logic [V_W-1:0] v_cnt;
    logic           href_d;
    logic           vsync_seen;
    logic           href_rise;
    logic           href_fall;
    logic           free_run;
    logic           gap_done;

    assign href_rise = cam_href && !href_d;
    assign href_fall = !cam_href && href_d;
    assign free_run  = state inside {video_pkg::active_wait_ref, video_pkg::active_h_active,
                                     video_pkg::active_h_fp, video_pkg::active_h_sync};
    assign gap_done  = (h_total == '0) || (h_cnt == h_total - 1'b1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= video_pkg::passive_wait_ref;
            h_cnt      <= '0;
            h_total    <= '0;
            v_cnt      <= '0;
            hsync      <= 1'b0;
            vsync_seen <= 1'b0;
        end else begin
            if (cam_vsync) begin
                vsync_seen <= 1'b1;
            end

            case (state)
                video_pkg::passive_wait_ref: begin
                    if (href_rise) begin
                        state <= video_pkg::passive_h_active;
                    end else begin
                        // a camera frame start restarts the line count here.
                        if (vsync_seen) begin
                            vsync_seen <= 1'b0;
                            v_cnt      <= '0;
                        end
                        if (h_total != '1) begin
                            h_total <= h_total + 1'b1;
                        end
                    end
                end

                video_pkg::passive_h_active: begin
                    if (href_fall) begin
                        v_cnt <= v_cnt + 1'b1;
                        h_cnt <= '0;
                        state <= video_pkg::passive_h_fp;
                    end
                end

                video_pkg::active_wait_ref: begin
                    if (gap_done) begin
                        h_cnt <= '0;
                        state <= video_pkg::active_h_active;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end

                video_pkg::active_h_active: begin
                    if (h_cnt == H_W'(H_ACT - 1)) begin
                        h_cnt <= '0;
                        v_cnt <= v_cnt + 1'b1;
                        state <= video_pkg::active_h_fp;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end

                video_pkg::passive_h_fp,
                video_pkg::active_h_fp: begin
                    if (h_cnt == H_W'(H_FP - 1)) begin
                        h_cnt <= '0;
                        hsync <= 1'b1;
                        state <= free_run ? video_pkg::active_h_sync
                                          : video_pkg::passive_h_sync;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end

                video_pkg::passive_h_sync,
                video_pkg::active_h_sync: begin
                    if (h_cnt == H_W'(H_SYNC - 1)) begin
                        h_cnt <= '0;
                        hsync <= 1'b0;
                        if (!free_run && v_cnt == V_W'(V_ACT)) begin
                            // after the last visible line the blanking lines run free.
                            state <= video_pkg::active_wait_ref;
                        end else if (!free_run || v_cnt == V_W'(V_TOTAL)) begin
                            if (free_run) begin
                                v_cnt <= '0;
                            end
                            h_total <= '0;
                            state   <= video_pkg::passive_wait_ref;
                        end else begin
                            state <= video_pkg::active_wait_ref;
                        end
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end

                default: begin
                    state <= video_pkg::passive_wait_ref;
                end
            endcase
        end
    end

    // in locked lines de is href delayed by one cycle.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            href_d <= 1'b0;
            vsync  <= 1'b0;
            de     <= 1'b0;
        end else begin
            href_d <= cam_href;
            vsync  <= (v_cnt >= V_W'(V_ACT + V_FP)) && (v_cnt < V_W'(V_TOTAL));
            if (free_run) begin
                de <= (state == video_pkg::active_h_active);
            end else begin
                de <= cam_href && (v_cnt < V_W'(V_ACT)) &&
                      (state inside {video_pkg::passive_wait_ref, video_pkg::passive_h_active});
            end
        end
    end

    a_no_hsync_in_active: assert property (
        @(posedge clk) disable iff (!rstn)
        (state inside {video_pkg::passive_h_active, video_pkg::active_h_active}) |-> !hsync
    ) else $error("hsync high during an active line state");

    a_de_hsync_exclusive: assert property (
        @(posedge clk) disable iff (!rstn)
        !(de && hsync)
    ) else $error("de and hsync high together");

    a_state_legal: assert property (
        @(posedge clk) disable iff (!rstn)
        !$isunknown(state) &&
        (state inside {video_pkg::passive_h_active, video_pkg::passive_h_fp,
                       video_pkg::passive_h_sync, video_pkg::passive_wait_ref,
                       video_pkg::active_wait_ref, video_pkg::active_h_active,
                       video_pkg::active_h_fp, video_pkg::active_h_sync})
    ) else $error("sync_gen state outside its encoding");

endmodule : sync_gen

/* rtl/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer #(
    parameter int H_ACT  = 1280,
    parameter int DATA_W = 8
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              cam_href,
    input  logic [DATA_W-1:0] cam_data,
    input  logic              de,
    output logic [DATA_W-1:0] pix_data
);

    // the counters must reach H_ACT itself while the memory index stops at H_ACT-1.
    localparam int AW = $clog2(H_ACT + 1);
    localparam int IW = $clog2(H_ACT);

    logic [DATA_W-1:0] mem [2][H_ACT];

    video_pkg::rd_state_t rd_state;

    logic          bank_sel;
    logic          href_d;
    logic          wr_bank;
    logic          rd_bank;
    logic [AW-1:0] wr_addr [2];
    logic [AW-1:0] rd_addr [2];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    // the camera fills one bank while the display replays the other.
    assign wr_bank = bank_sel;
    assign rd_bank = !bank_sel;
    assign wr_ptr  = wr_addr[wr_bank];
    assign rd_ptr  = rd_addr[rd_bank];

    always_ff @(posedge clk) begin
        if (cam_href) begin
            mem[wr_bank][wr_ptr[IW-1:0]] <= cam_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            href_d     <= 1'b0;
            bank_sel   <= 1'b0;
            wr_addr[0] <= '0;
            wr_addr[1] <= '0;
        end else begin
            href_d <= cam_href;
            if (cam_href) begin
                wr_addr[wr_bank] <= wr_ptr + 1'b1;
            end else if (href_d) begin
                // at the end of a camera line the full bank becomes the read bank.
                wr_addr[wr_bank] <= '0;
                bank_sel         <= !bank_sel;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_state   <= video_pkg::rd_idle;
            rd_addr[0] <= '0;
            rd_addr[1] <= '0;
            pix_data   <= '0;
        end else begin
            case (rd_state)
                video_pkg::rd_idle: begin
                    if (de) begin
                        pix_data         <= mem[rd_bank][0];
                        rd_addr[rd_bank] <= AW'(1);
                        rd_state         <= video_pkg::rd_run;
                    end
                end
                video_pkg::rd_run: begin
                    if (de) begin
                        pix_data         <= mem[rd_bank][rd_ptr[IW-1:0]];
                        rd_addr[rd_bank] <= rd_ptr + 1'b1;
                    end else begin
                        // the bank may have swapped at the line end, so both are cleared.
                        pix_data   <= '0;
                        rd_addr[0] <= '0;
                        rd_addr[1] <= '0;
                        rd_state   <= video_pkg::rd_idle;
                    end
                end
                default: begin
                    rd_state <= video_pkg::rd_idle;
                end
            endcase
        end
    end

    a_wr_in_range: assert property (
        @(posedge clk) disable iff (!rstn)
        cam_href |-> (wr_ptr < AW'(H_ACT))
    ) else $error("camera line longer than the line buffer");

endmodule : line_buffer

/* rtl/cam_to_video_top.sv */
`timescale 1ns/1ps

module cam_to_video_top #(
    parameter int H_ACT  = 1280,
    parameter int H_FP   = 110,
    parameter int H_SYNC = 40,
    parameter int V_ACT  = 720,
    parameter int V_FP   = 5,
    parameter int V_SYNC = 5,
    parameter int DATA_W = 8
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              cam_href,
    input  logic              cam_vsync,
    input  logic [DATA_W-1:0] cam_data,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output logic [DATA_W-1:0] pix_data
);

    // display timing locked to the camera lines.
    sync_gen #(
        .H_ACT  (H_ACT),
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .V_ACT  (V_ACT),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC)
    ) u_sync_gen (
        .clk       (clk),
        .rstn      (rstn),
        .cam_href  (cam_href),
        .cam_vsync (cam_vsync),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de)
    );

    // each display line replays the previous camera line.
    line_buffer #(
        .H_ACT  (H_ACT),
        .DATA_W (DATA_W)
    ) u_line_buffer (
        .clk      (clk),
        .rstn     (rstn),
        .cam_href (cam_href),
        .cam_data (cam_data),
        .de       (de),
        .pix_data (pix_data)
    );

endmodule : cam_to_video_top

/* tb/tb_cam_to_video.sv */
`timescale 1ns/1ps

module tb_cam_to_video;

    localparam int H_ACT  = 16;
    localparam int H_FP   = 4;
    localparam int H_SYNC = 3;
    localparam int V_ACT  = 6;
    localparam int V_FP   = 2;
    localparam int V_SYNC = 2;
    localparam int DATA_W = 8;

    // one hsync pulse per line of the frame, visible and blanking lines alike.
    localparam int N_DISP  = V_ACT + V_FP + V_SYNC;
    localparam int SEED    = 66435;
    localparam int TIMEOUT = 2000;
    localparam int QUIET   = 80;

    logic              clk = 1'b0;
    logic              rstn;
    logic              cam_href;
    logic              cam_vsync;
    logic [DATA_W-1:0] cam_data;
    logic              hsync;
    logic              vsync;
    logic              de;
    logic [DATA_W-1:0] pix_data;

    // one row per camera line holds the idle cycles before it and its frame-start pulse.
    int gap_tab [V_ACT] = '{12, 10, 15, 11, 20, 13};
    bit vs_tab  [V_ACT] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    // the camera line replayed on each display line, or -1 while the read bank is still empty.
    int src_tab [N_DISP] = '{-1, 0, 1, 2, 3, 4, 5, 5, 5, 5};

    int cyc = 0;
    int pix_offset;
    int exp_gap;
    bit mon_en = 1'b0;
    int drop_q [$];
    int drop_cyc;

    int hs_count = 0;
    int vs_hs_count = 0;
    int hs_len = 0;
    int last_rise = 0;
    bit hs_d = 1'b0;

    int disp_line = 0;
    int de_len = 0;
    int pix_idx = 0;
    bit de_d = 1'b0;

    cam_to_video_top #(
        .H_ACT  (H_ACT),
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .V_ACT  (V_ACT),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .DATA_W (DATA_W)
    ) u_dut (
        .clk       (clk),
        .rstn      (rstn),
        .cam_href  (cam_href),
        .cam_vsync (cam_vsync),
        .cam_data  (cam_data),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .pix_data  (pix_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [DATA_W-1:0] pixel_value(input int line, input int idx);
        return DATA_W'(line * 16 + idx + pix_offset);
    endfunction

    task automatic drive_row(input int row);
        int k;
        int idle;
        // for later rows the falling edge of the previous line is the first idle cycle.
        idle = (row == 0) ? gap_tab[row] : gap_tab[row] - 1;
        for (k = 0; k < idle; k++) begin
            @(negedge clk);
            cam_vsync = vs_tab[row] && (k == idle / 2);
        end
        for (k = 0; k < H_ACT; k++) begin
            @(negedge clk);
            cam_vsync = 1'b0;
            cam_href  = 1'b1;
            cam_data  = pixel_value(row, k);
        end
        @(negedge clk);
        cam_href = 1'b0;
        cam_data = '0;
        drop_q.push_back(cyc);
    endtask

    task automatic wait_hsync_count(input int target);
        int n;
        n = 0;
        while (hs_count < target) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("timeout while waiting for the hsync pulses of the frame");
            end
        end
    endtask

    // the hsync monitor checks camera lock, free-running period, width and vsync overlap.
    always @(negedge clk) begin
        if (mon_en) begin
            if (hsync && !hs_d) begin
                if (hs_count < V_ACT) begin
                    if (drop_q.size() == 0) begin
                        abort_run("hsync pulse without a camera line before it");
                    end
                    drop_cyc = drop_q.pop_front();
                    check_val("hsync delay", cyc - drop_cyc, H_FP + 1);
                end else begin
                    check_val("hsync period", cyc - last_rise,
                              exp_gap + H_ACT + H_FP + H_SYNC);
                end
                if (vsync) begin
                    vs_hs_count++;
                end
                last_rise = cyc;
                hs_count++;
                hs_len = 0;
            end
            if (hsync) begin
                hs_len++;
            end else if (hs_d) begin
                check_val("hsync width", hs_len, H_SYNC);
            end
            hs_d = hsync;
        end
    end

    // the de monitor checks run lengths and pix_data, which trails each de cycle by one clock.
    always @(negedge clk) begin
        if (mon_en) begin
            if (de_d) begin
                if (disp_line >= N_DISP) begin
                    abort_run("de active after the last display line of the frame");
                end
                if (src_tab[disp_line] >= 0) begin
                    check_val("pix_data", pix_data, pixel_value(src_tab[disp_line], pix_idx));
                end
                pix_idx++;
            end
            if (de) begin
                de_len++;
            end else if (de_d) begin
                check_val("de length", de_len, H_ACT);
                disp_line++;
                de_len  = 0;
                pix_idx = 0;
            end
            de_d = de;
        end
    end

    initial begin
        int row;
        int k;

        void'($urandom(SEED));
        pix_offset = int'($urandom % 256);
        // the generator counts idle cycles from the end of hsync, less one for the edge detect.
        exp_gap = gap_tab[V_ACT-1] - (H_FP + H_SYNC + 1);

        rstn      = 1'b0;
        cam_href  = 1'b0;
        cam_vsync = 1'b0;
        cam_data  = '0;

        for (k = 0; k < 8; k++) begin
            @(negedge clk);
            check_val("hsync", hsync, 0);
            check_val("vsync", vsync, 0);
            check_val("de", de, 0);
            check_val("pix_data", pix_data, 0);
        end
        rstn = 1'b1;
        @(negedge clk);
        check_val("hsync", hsync, 0);
        check_val("vsync", vsync, 0);
        check_val("de", de, 0);
        check_val("pix_data", pix_data, 0);
        mon_en <= 1'b1;

        for (row = 0; row < V_ACT; row++) begin
            drive_row(row);
        end

        // href stays low from here on, so the rest of the frame runs free.
        wait_hsync_count(N_DISP);
        for (k = 0; k < QUIET; k++) begin
            @(posedge clk);
        end

        check_val("hsync count", hs_count, N_DISP);
        check_val("display lines", disp_line, N_DISP);
        check_val("hsync under vsync", vs_hs_count, V_SYNC);

        $display("Test completed successfully");
        $finish;
    end

endmodule : tb_cam_to_video

/* project.f */
rtl/video_pkg.sv
rtl/sync_gen.sv
rtl/line_buffer.sv
rtl/cam_to_video_top.sv
tb/tb_cam_to_video.sv

/* Makefile */
# Verilator build and run of the camera to video bridge.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_cam_to_video
FILELIST  ?= project.f

PASS_MSG  := Test completed successfully
SIM_BIN   := obj_dir/V$(TOP)

.PHONY: test clean help

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "^$(PASS_MSG)$$"; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"
